// File: hw/la_pkg.sv
package la_pkg;

	// capture geometry
	localparam int LA_CH    = 10;       // input channels
	localparam int LA_AW    = 10;       // capture address bits
	localparam int LA_DEPTH = 1024;     // words per capture
	localparam int CNT_W    = LA_AW + 1; // write count reaches LA_DEPTH itself
	localparam int DIV_W    = 16;       // sample divisor width
	localparam int CHSEL_W  = 4;        // trigger channel select width

	// host bus
	localparam int AXI_AW = 13;  // 8 KiB of address space
	localparam int AXI_DW = 32;
	localparam logic [1:0] AXI_OKAY = 2'b00;

	typedef enum logic [2:0] {
		TRIG_ALWAYS = 3'd0,  // fire right after arm
		TRIG_LOW    = 3'd1,
		TRIG_FALL   = 3'd2,
		TRIG_RISE   = 3'd3,
		TRIG_HIGH   = 3'd4,
		TRIG_BOTH   = 3'd5   // codes 6 and 7 never fire
	} trig_mode_e;

	// register map, byte offsets
	localparam logic [AXI_AW-1:0] REG_CTRL   = 13'h0000;
	localparam logic [AXI_AW-1:0] REG_DIV    = 13'h0004;
	localparam logic [AXI_AW-1:0] REG_STATUS = 13'h0008;
	localparam logic [AXI_AW-1:0] MEM_BASE   = 13'h1000; // 4 KiB, one word per sample

	// CTRL fields
	localparam int CTRL_RUN       = 0;  // write-only pulse
	localparam int CTRL_STOP      = 1;  // write-only pulse
	localparam int CTRL_MSEL_LSB  = 2;  // msel in 4:2
	localparam int CTRL_CHSEL_LSB = 8;  // chsel in 11:8

	// STATUS fields
	localparam int STAT_ARMED     = 0;
	localparam int STAT_DONE      = 1;
	localparam int STAT_COUNT_LSB = 16; // count from bit 16 up, 1024 sets bit 26

endpackage

// File: hw/la_ctrl_if.sv
`timescale 1ns/10ps

interface la_ctrl_if;

	// host side
	logic                      run;       // one-cycle arm pulse
	logic                      stop;      // one-cycle abort pulse
	la_pkg::trig_mode_e        msel;      // trigger mode
	logic [la_pkg::CHSEL_W-1:0] chsel;    // trigger channel
	logic [la_pkg::DIV_W-1:0]  rate_div;  // strobe every rate_div+1 clocks

	// capture side
	logic                      armed;
	logic                      done;
	logic [la_pkg::CNT_W-1:0]  count;     // words written so far

	modport regs (output run, stop, msel, chsel, rate_div, input armed, done, count);
	modport cap  (input run, stop, msel, chsel, output armed, done, count);
	modport div  (input run, rate_div);

endinterface

// File: hw/sample_rate_div.sv
`timescale 1ns/10ps

module sample_rate_div (
	input  logic   clk_s,
	input  logic   rst_n,
	la_ctrl_if.div ctrl,
	output logic   en_sap   // one-cycle sample strobe
);

	logic [la_pkg::DIV_W-1:0] cnt; // clocks left until next strobe

	always_ff @(posedge clk_s or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			en_sap <= 1'b0;
		end else if (ctrl.run) begin
			// phase restart so the first sample lands a fixed time after arm
			cnt    <= ctrl.rate_div;
			en_sap <= (ctrl.rate_div == '0); // divisor 0 keeps strobing every cycle
		end else if (cnt == '0) begin
			cnt    <= ctrl.rate_div; // reload
			en_sap <= 1'b1;
		end else begin
			cnt    <= cnt - 1'b1;
			en_sap <= 1'b0;
		end
	end

endmodule

// File: hw/wave_sap.sv
`timescale 1ns/10ps

module wave_sap (
	input  logic                     clk_s,
	input  logic                     rst_n,
	input  logic [la_pkg::LA_CH-1:0] ch,      // raw channel pins, asynchronous
	input  logic                     en_sap,  // sample strobe
	la_ctrl_if.cap                   ctrl,
	output logic                     wr_en,   // ram write port
	output logic [la_pkg::LA_AW-1:0] wraddr,
	output logic [la_pkg::LA_CH-1:0] wrdata
);

	logic [la_pkg::LA_CH-1:0]          ch_m;     // first sync stage, may go metastable
	logic [la_pkg::LA_CH-1:0]          ch_s;     // second stage, safe to use
	logic [la_pkg::LA_CH-1:0]          ch_d;     // ch_s one cycle older, for edges
	logic [(1 << la_pkg::CHSEL_W)-1:0] flag_pad; // per-channel flags, padded to chsel range
	logic                              trig_q;   // registered trigger flag
	logic                              armed;
	logic                              trig;     // trigger seen, samples flowing
	logic                              done;
	logic [la_pkg::LA_AW-1:0]          addr;     // next write address
	logic                              last_wr;

	always_ff @(posedge clk_s) begin
		ch_m <= ch;
		ch_s <= ch_m;
		ch_d <= ch_s;
	end

	// level and edge flags for every channel, chosen by mode
	always_comb begin
		flag_pad = '0; // channels above LA_CH never fire
		case (ctrl.msel)
			la_pkg::TRIG_ALWAYS: flag_pad = '1;
			la_pkg::TRIG_LOW:    flag_pad[la_pkg::LA_CH-1:0] = ~ch_s;
			la_pkg::TRIG_FALL:   flag_pad[la_pkg::LA_CH-1:0] = ~ch_s & ch_d;
			la_pkg::TRIG_RISE:   flag_pad[la_pkg::LA_CH-1:0] = ch_s & ~ch_d;
			la_pkg::TRIG_HIGH:   flag_pad[la_pkg::LA_CH-1:0] = ch_s;
			la_pkg::TRIG_BOTH:   flag_pad[la_pkg::LA_CH-1:0] = ch_s ^ ch_d;
			default: ;                                 // 6 and 7 stay quiet
		endcase
	end

	assign wr_en   = armed & trig & en_sap;   // one write per strobe after trigger
	assign last_wr = wr_en & (&addr);        // top address, depth is a power of two

	always_ff @(posedge clk_s or negedge rst_n) begin
		if (!rst_n) begin
			trig_q <= 1'b0;
			armed  <= 1'b0;
			trig   <= 1'b0;
			done   <= 1'b0;
			addr   <= '0;
		end else begin
			trig_q <= flag_pad[ctrl.chsel];
			if (ctrl.run && !armed) begin
				// new capture
				armed <= 1'b1;
				trig  <= 1'b0;
				done  <= 1'b0;
				addr  <= '0;
			end else if (ctrl.stop) begin
				armed <= 1'b0; // abort, done untouched
				trig  <= 1'b0;
			end else begin
				if (armed && !trig && trig_q)
					trig <= 1'b1;
				if (wr_en)
					addr <= addr + 1'b1; // wraps to 0 after the last word
				if (last_wr) begin
					armed <= 1'b0;
					trig  <= 1'b0;
					done  <= 1'b1; // holds until next run
				end
			end
		end
	end

	assign wraddr = addr;
	assign wrdata = ch_s;

	// address wraps to 0 exactly when done rises, so done is the count msb
	assign ctrl.count = {done, addr};
	assign ctrl.armed = armed;
	assign ctrl.done  = done;

endmodule

// File: hw/capture_ram.sv
`timescale 1ns/10ps

module capture_ram (
	input  logic                     clk_s,
	input  logic                     wr_en,
	input  logic [la_pkg::LA_AW-1:0] wraddr,
	input  logic [la_pkg::LA_CH-1:0] wrdata,
	input  logic [la_pkg::LA_AW-1:0] rdaddr,
	output logic [la_pkg::LA_CH-1:0] rddata  // one clock after rdaddr
);

	logic [la_pkg::LA_CH-1:0] mem [la_pkg::LA_DEPTH]; // maps to block ram

	// write port, capture side
	always_ff @(posedge clk_s) begin
		if (wr_en)
			mem[wraddr] <= wrdata;
	end

	// read port, host side, registered output
	always_ff @(posedge clk_s) begin
		rddata <= mem[rdaddr];
	end

endmodule

// File: hw/axil_regs.sv
`timescale 1ns/10ps

module axil_regs (
	input  logic                      clk_s,
	input  logic                      rst_n,
	// write address / data / response
	input  logic [la_pkg::AXI_AW-1:0] awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [la_pkg::AXI_DW-1:0] wdata,
	input  logic [3:0]                wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output logic [1:0]                bresp,
	output logic                      bvalid,
	input  logic                      bready,
	// read address / data
	input  logic [la_pkg::AXI_AW-1:0] araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output logic [la_pkg::AXI_DW-1:0] rdata,
	output logic [1:0]                rresp,
	output logic                      rvalid,
	input  logic                      rready,
	// capture control
	la_ctrl_if.regs                   ctrl,
	// ram read port
	output logic [la_pkg::LA_AW-1:0]  rdaddr,
	input  logic [la_pkg::LA_CH-1:0]  rddata
);

	logic                      aw_rdy;    // shared awready / wready
	logic                      wr_hs;
	logic [la_pkg::AXI_AW-1:0] wa;        // word aligned write address
	logic                      run_q;
	logic                      stop_q;
	la_pkg::trig_mode_e        msel_q;
	logic [la_pkg::CHSEL_W-1:0] chsel_q;
	logic [la_pkg::DIV_W-1:0]  div_q;
	logic                      ar_rdy;
	logic                      ar_hs;
	logic                      ar_mem;    // read hits the memory window
	logic                      mem_pend;  // ram read in flight
	logic [la_pkg::AXI_DW-1:0] reg_rd;    // register read mux
	logic [la_pkg::AXI_DW-1:0] mem_word;
	logic [la_pkg::AXI_DW-1:0] rdata_q;

	assign wr_hs = aw_rdy & awvalid & wvalid;
	assign wa    = {awaddr[la_pkg::AXI_AW-1:2], 2'b00};

	always_ff @(posedge clk_s or negedge rst_n) begin
		if (!rst_n) begin
			aw_rdy  <= 1'b0;
			bvalid  <= 1'b0;
			run_q   <= 1'b0;
			stop_q  <= 1'b0;
			msel_q  <= la_pkg::TRIG_ALWAYS;
			chsel_q <= '0;
			div_q   <= '0;
		end else begin
			// accept aw and w together, only with no response outstanding
			aw_rdy <= awvalid & wvalid & ~aw_rdy & ~bvalid;
			run_q  <= 1'b0; // pulses last one cycle
			stop_q <= 1'b0;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (wr_hs && wa == la_pkg::REG_CTRL) begin
				if (wstrb[0]) begin
					run_q  <= wdata[la_pkg::CTRL_RUN];
					stop_q <= wdata[la_pkg::CTRL_STOP];
					msel_q <= la_pkg::trig_mode_e'(
						wdata[la_pkg::CTRL_MSEL_LSB +: $bits(la_pkg::trig_mode_e)]);
				end
				if (wstrb[1])
					chsel_q <= wdata[la_pkg::CTRL_CHSEL_LSB +: la_pkg::CHSEL_W];
			end
			if (wr_hs && wa == la_pkg::REG_DIV) begin
				if (wstrb[0])
					div_q[7:0] <= wdata[7:0];
				if (wstrb[1])
					div_q[15:8] <= wdata[15:8];
			end
		end
	end

	assign awready = aw_rdy;
	assign wready  = aw_rdy;
	assign bresp   = la_pkg::AXI_OKAY;

	assign ar_hs  = ar_rdy & arvalid;
	assign ar_mem = (araddr >= la_pkg::MEM_BASE);
	assign rdaddr = araddr[la_pkg::LA_AW+1:2]; // ram samples it at the handshake edge

	// register reads, run and stop read back as zero
	always_comb begin
		reg_rd = '0;
		case ({araddr[la_pkg::AXI_AW-1:2], 2'b00})
			la_pkg::REG_CTRL: begin
				reg_rd[la_pkg::CTRL_MSEL_LSB +: $bits(la_pkg::trig_mode_e)] = msel_q;
				reg_rd[la_pkg::CTRL_CHSEL_LSB +: la_pkg::CHSEL_W] = chsel_q;
			end
			la_pkg::REG_DIV:
				reg_rd[la_pkg::DIV_W-1:0] = div_q;
			la_pkg::REG_STATUS: begin
				reg_rd[la_pkg::STAT_ARMED] = ctrl.armed;
				reg_rd[la_pkg::STAT_DONE]  = ctrl.done;
				reg_rd[la_pkg::STAT_COUNT_LSB +: la_pkg::CNT_W] = ctrl.count;
			end
			default: ; // unmapped reads zero
		endcase
	end

	assign mem_word = {{(la_pkg::AXI_DW - la_pkg::LA_CH){1'b0}}, rddata};

	always_ff @(posedge clk_s or negedge rst_n) begin
		if (!rst_n) begin
			ar_rdy   <= 1'b0;
			mem_pend <= 1'b0;
			rvalid   <= 1'b0;
		end else begin
			// no new request while data is pending or held
			ar_rdy   <= arvalid & ~ar_rdy & ~rvalid & ~mem_pend;
			mem_pend <= ar_hs & ar_mem;
			if ((ar_hs && !ar_mem) || mem_pend)
				rvalid <= 1'b1; // regs after 1 cycle, memory after 2
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// read data, stable while rvalid waits for rready
	always_ff @(posedge clk_s) begin
		if (ar_hs && !ar_mem)
			rdata_q <= reg_rd;
		else if (mem_pend)
			rdata_q <= mem_word; // extra stage behind the ram register
	end

	assign arready = ar_rdy;
	assign rdata   = rdata_q;
	assign rresp   = la_pkg::AXI_OKAY;

	assign ctrl.run      = run_q;
	assign ctrl.stop     = stop_q;
	assign ctrl.msel     = msel_q;
	assign ctrl.chsel    = chsel_q;
	assign ctrl.rate_div = div_q;

endmodule

// File: hw/la_top.sv
`timescale 1ns/10ps

module la_top (
	input  logic                      clk_s,
	input  logic                      rst_n,
	input  logic [la_pkg::LA_CH-1:0]  ch,       // analyzer inputs
	// axi4-lite slave
	input  logic [la_pkg::AXI_AW-1:0] awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [la_pkg::AXI_DW-1:0] wdata,
	input  logic [3:0]                wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output logic [1:0]                bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  logic [la_pkg::AXI_AW-1:0] araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output logic [la_pkg::AXI_DW-1:0] rdata,
	output logic [1:0]                rresp,
	output logic                      rvalid,
	input  logic                      rready,
	output logic                      done      // capture complete, level
);

	logic                     en_sap;
	logic                     wr_en;
	logic [la_pkg::LA_AW-1:0] wraddr;
	logic [la_pkg::LA_CH-1:0] wrdata;
	logic [la_pkg::LA_AW-1:0] rdaddr;
	logic [la_pkg::LA_CH-1:0] rddata;

	la_ctrl_if u_ctrl ();

	sample_rate_div u_div (
		.clk_s  (clk_s),
		.rst_n  (rst_n),
		.ctrl   (u_ctrl.div),
		.en_sap (en_sap)
	);

	wave_sap u_sap (
		.clk_s  (clk_s),
		.rst_n  (rst_n),
		.ch     (ch),
		.en_sap (en_sap),
		.ctrl   (u_ctrl.cap),
		.wr_en  (wr_en),
		.wraddr (wraddr),
		.wrdata (wrdata)
	);

	capture_ram u_ram (
		.clk_s  (clk_s),
		.wr_en  (wr_en),
		.wraddr (wraddr),
		.wrdata (wrdata),
		.rdaddr (rdaddr),
		.rddata (rddata)
	);

	axil_regs u_regs (
		.clk_s   (clk_s),
		.rst_n   (rst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.ctrl    (u_ctrl.regs),
		.rdaddr  (rdaddr),
		.rddata  (rddata)
	);

	assign done = u_ctrl.done;

endmodule

// File: sim/tb_la_top.sv
`timescale 1ns/10ps

module tb_la_top;

	localparam logic [31:0] STAT_FULL = (32'(la_pkg::LA_DEPTH) << la_pkg::STAT_COUNT_LSB)
		| (32'd1 << la_pkg::STAT_DONE);                   // done, not armed, count 1024
	localparam int CAP_CYC   = la_pkg::LA_DEPTH * (16 + 12 + 1); // divisor 15, readback, trigger
	localparam int WATCH_CYC = 7 * CAP_CYC + 2000 + 5000;  // seven captures, abort wait, margin

	logic        clk_s;
	logic        rst_n;
	logic [9:0]  ch;
	logic [12:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [12:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        done;

	logic [31:0] lfsr;       // random source
	logic [9:0]  pat;        // free-running channel pattern
	logic        rv_hold;    // rvalid waiting on rready at last negedge
	logic [31:0] rdata_hold;

	la_top u_dut (.*);

	assign ch = pat;

	initial begin
		clk_s = 1'b0;
		forever #10 clk_s = ~clk_s;
	end

	// bit k holds each level for 2**k cycles
	always @(posedge clk_s) begin
		#2;
		pat <= pat + 10'd1;
	end

	initial begin
		repeat (WATCH_CYC) @(posedge clk_s);
		$display("watchdog expired, the tests did not finish in time");
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end

	task automatic report_mismatch(input string name, input logic [31:0] want,
			input logic [31:0] got);
		$display("Fail at %0t: %s expected 0x%0h, got 0x%0h", $time, name, want, got);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] ctrl_word(input logic [2:0] mode, input int k,
			input bit run, input bit stop);
		logic [31:0] w;
		w = '0;
		w[la_pkg::CTRL_RUN]  = run;
		w[la_pkg::CTRL_STOP] = stop;
		w[la_pkg::CTRL_MSEL_LSB +: 3]  = mode;
		w[la_pkg::CTRL_CHSEL_LSB +: 4] = 4'(k);
		return w;
	endfunction

	task automatic step();
		@(posedge clk_s);
		#2; // all drives and samples sit here
	endtask

	task automatic axil_write(input logic [12:0] addr, input logic [31:0] data);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		while (!awready) step();
		step(); // handshake edge
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		while (!bvalid) step();
		step();
		bready  = 1'b0;
	endtask

	task automatic axil_read(input logic [12:0] addr, output logic [31:0] data);
		int delay;
		araddr  = addr;
		arvalid = 1'b1;
		while (!arready) step();
		step();
		arvalid = 1'b0;
		while (!rvalid) step();
		delay = int'(rand_bits(2)); // 0..3 cycles of back-pressure
		repeat (delay) step();
		rready = 1'b1;
		data   = rdata;
		step();
		rready = 1'b0;
	endtask

	// second request sits on the bus while the first response is held back
	task automatic read_back_to_back(input logic [12:0] addr_a, input logic [12:0] addr_b,
			output logic [31:0] data_a, output logic [31:0] data_b);
		araddr  = addr_a;
		arvalid = 1'b1;
		while (!arready) step();
		step();
		araddr = addr_b; // next request up right away
		while (!rvalid) step();
		repeat (int'(rand_bits(2)) + 1) step();
		rready = 1'b1;
		data_a = rdata;
		step();
		rready = 1'b0;
		while (!arready) step();
		step();
		arvalid = 1'b0;
		while (!rvalid) step();
		rready = 1'b1;
		data_b = rdata;
		step();
		rready = 1'b0;
	endtask

	// arm one capture, wait for done, check status and optionally the whole record
	task automatic capture(input logic [2:0] mode, input int k, input logic [15:0] d,
			input bit full, output logic [9:0] first, output logic [9:0] at_run);
		logic [31:0] w;
		logic [31:0] want;
		logic [9:0]  prev;
		axil_write(la_pkg::REG_DIV, {16'h0, d});
		// keep clear of a level change on bit k right around arm
		while ((pat & ((10'd1 << k) - 10'd1)) > ((10'd1 << k) - 10'd40)) step();
		at_run = pat;
		axil_write(la_pkg::REG_CTRL, ctrl_word(mode, k, 1'b1, 1'b0));
		while (!done) step();
		axil_read(la_pkg::REG_STATUS, w);
		assert (w == STAT_FULL) else report_mismatch("status", STAT_FULL, w);
		axil_read(la_pkg::MEM_BASE, w);
		first = w[9:0];
		prev  = first;
		if (full) begin
			for (int i = 1; i < la_pkg::LA_DEPTH; i++) begin
				axil_read(la_pkg::MEM_BASE + 13'(i * 4), w);
				want = {22'h0, 10'(prev + d + 16'd1)}; // pattern moves d+1 per sample
				assert (w == want) else report_mismatch($sformatf("mem[%0d]", i), want, w);
				prev = w[9:0];
			end
		end
	endtask

	// bus protocol watch, mid-cycle where outputs are settled
	always @(negedge clk_s) begin
		if (rst_n) begin
			assert (bresp == 2'b00) else report_mismatch("bresp", 0, bresp);
			assert (rresp == 2'b00) else report_mismatch("rresp", 0, rresp);
			assert (wready == awready) else report_mismatch("wready", awready, wready);
			assert (!(rvalid && arready)) else report_mismatch("arready", 0, arready);
			if (rv_hold) begin
				assert (rvalid) else report_mismatch("rvalid", 1, rvalid);
				assert (rdata == rdata_hold) else report_mismatch("rdata", rdata_hold, rdata);
			end
			rv_hold    <= rvalid & ~rready;
			rdata_hold <= rdata;
		end
	end

	initial begin
		logic [31:0] w;
		logic [31:0] w2;
		logic [31:0] want;
		logic [9:0]  first;
		logic [9:0]  at_run;
		logic [15:0] d;
		int          k;
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		pat     = '0;
		rv_hold = 1'b0;
		lfsr    = 32'hf6a8;
		repeat (4) @(posedge clk_s);
		#2;
		rst_n = 1'b1;

		// reset state and register readback
		assert (!done) else report_mismatch("done", 0, done);
		assert (!bvalid) else report_mismatch("bvalid", 0, bvalid);
		assert (!rvalid) else report_mismatch("rvalid", 0, rvalid);
		assert (!awready) else report_mismatch("awready", 0, awready);
		assert (!wready) else report_mismatch("wready", 0, wready);
		assert (!arready) else report_mismatch("arready", 0, arready);
		axil_read(la_pkg::REG_STATUS, w);
		assert (w == 32'h0) else report_mismatch("status", 0, w);
		axil_write(la_pkg::REG_CTRL, ctrl_word(la_pkg::TRIG_HIGH, 7, 1'b0, 1'b1));
		axil_read(la_pkg::REG_CTRL, w);
		assert (w == ctrl_word(la_pkg::TRIG_HIGH, 7, 1'b0, 1'b0))
			else report_mismatch("ctrl", ctrl_word(la_pkg::TRIG_HIGH, 7, 1'b0, 1'b0), w);
		d = 16'(rand_bits(16));
		axil_write(la_pkg::REG_DIV, {16'h0, d});
		axil_read(la_pkg::REG_DIV, w);
		assert (w == {16'h0, d}) else report_mismatch("div", {16'h0, d}, w);

		// unconditional capture, full record
		d = 16'(rand_bits(4));
		capture(la_pkg::TRIG_ALWAYS, 6, d, 1'b1, first, at_run);

		// overlapped reads, the held response keeps the second request waiting
		read_back_to_back(la_pkg::MEM_BASE + 13'h8, la_pkg::REG_STATUS, w, w2);
		want = {22'h0, 10'(first + 16'd2 * (d + 16'd1))}; // two strobes after word 0
		assert (w == want) else report_mismatch("mem[2]", want, w);
		assert (w2 == STAT_FULL) else report_mismatch("status", STAT_FULL, w2);

		// edge triggers, first word only
		k = 6 + int'(rand_bits(2));
		capture(la_pkg::TRIG_RISE, k, 16'(rand_bits(4)), 1'b0, first, at_run);
		assert (first[k] == 1'b1) else report_mismatch($sformatf("mem[0][%0d]", k), 1, first[k]);
		k = 6 + int'(rand_bits(2));
		capture(la_pkg::TRIG_FALL, k, 16'(rand_bits(4)), 1'b0, first, at_run);
		assert (first[k] == 1'b0) else report_mismatch($sformatf("mem[0][%0d]", k), 0, first[k]);
		k = 6 + int'(rand_bits(2));
		capture(la_pkg::TRIG_BOTH, k, 16'(rand_bits(4)), 1'b0, first, at_run);
		assert (first[k] != at_run[k])
			else report_mismatch($sformatf("mem[0][%0d]", k), !at_run[k], first[k]);

		// level triggers with the stepping check
		k = 6 + int'(rand_bits(2));
		capture(la_pkg::TRIG_HIGH, k, 16'(rand_bits(4)), 1'b1, first, at_run);
		assert (first[k] == 1'b1) else report_mismatch($sformatf("mem[0][%0d]", k), 1, first[k]);
		k = 6 + int'(rand_bits(2));
		capture(la_pkg::TRIG_LOW, k, 16'(rand_bits(4)), 1'b1, first, at_run);
		assert (first[k] == 1'b0) else report_mismatch($sformatf("mem[0][%0d]", k), 0, first[k]);

		// mode 6 never fires, then abort
		axil_write(la_pkg::REG_CTRL, ctrl_word(3'd6, 7, 1'b1, 1'b0));
		repeat (2000) step();
		axil_read(la_pkg::REG_STATUS, w);
		assert (w == 32'h1) else report_mismatch("status", 32'h1, w);
		axil_write(la_pkg::REG_CTRL, ctrl_word(3'd6, 7, 1'b0, 1'b1));
		axil_read(la_pkg::REG_STATUS, w);
		assert (w == 32'h0) else report_mismatch("status", 32'h0, w);
		capture(la_pkg::TRIG_ALWAYS, 6, 16'(rand_bits(4)), 1'b1, first, at_run);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: project.f
hw/la_pkg.sv
hw/la_ctrl_if.sv
hw/sample_rate_div.sv
hw/wave_sap.sv
hw/capture_ram.sv
hw/axil_regs.sv
hw/la_top.sv
sim/tb_la_top.sv

// File: Makefile
# verilator build and run of the capture core testbench

BIN := obj_dir/Vtb_la_top

.PHONY: run clean

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

$(BIN): project.f $(wildcard hw/*.sv sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_la_top \
		-f project.f -o Vtb_la_top

clean:
	rm -rf obj_dir sim.log
